// File: dcache_pkg.sv
package dcache_pkg;

    // ------------------------------------------------------------
    // geometry
    // ------------------------------------------------------------

    // core side
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // memory side, one beat is 16 bytes
    localparam int MEM_DATA_W = 128;
    localparam int MEM_ADDR_W = 28;

    // direct mapped, 8 sets of 64 byte lines
    localparam int SETS = 8;
    localparam int IDX_W = 3;
    localparam int OFF_W = 6;
    localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

    // four beats per line
    localparam int BEATS = 4;
    localparam int BEAT_W = 2;

    // data array row is set and beat together
    localparam int BANK_ADDR_W = IDX_W + BEAT_W;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------

    // bit 2 set means zero extension on loads
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } mem_dtype_t;

    // core request, 68 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        mem_dtype_t        dtype;
        logic              write;
    } core_req_t;

    // one writeback beat, 156 bits
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] data;
    } mem_wr_t;

    // row of the data array
    typedef struct packed {
        logic [IDX_W-1:0]  set;
        logic [BEAT_W-1:0] beat;
    } line_loc_t;

endpackage

// File: dcache_tag_array.sv
module dcache_tag_array import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] lookup_addr_i,
    input  logic              fill_done_i,
    input  logic [ADDR_W-1:0] fill_addr_i,
    input  logic              mark_dirty_i,
    output logic              hit_o,
    output logic              victim_dirty_o,
    output logic [TAG_W-1:0]  victim_tag_o
);

    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;
    logic [TAG_W-1:0] tag_q [SETS];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;

    assign lk_idx   = lookup_addr_i[OFF_W +: IDX_W];
    assign lk_tag   = lookup_addr_i[ADDR_W-1 -: TAG_W];
    assign fill_idx = fill_addr_i[OFF_W +: IDX_W];
    assign fill_tag = fill_addr_i[ADDR_W-1 -: TAG_W];

    // combinational lookup
    assign hit_o          = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign victim_dirty_o = valid_q[lk_idx] && dirty_q[lk_idx];
    assign victim_tag_o   = tag_q[lk_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            // fresh line comes in clean
            if (fill_done_i) begin
                valid_q[fill_idx] <= 1'b1;
                dirty_q[fill_idx] <= 1'b0;
            end
            if (mark_dirty_i) begin
                dirty_q[lk_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            tag_q[fill_idx] <= fill_tag;
        end
    end

    // refill end and store replay are separate FSM states
    assert property (@(posedge clk) disable iff (rst) !(fill_done_i && mark_dirty_i));

endmodule

// File: dcache_data_array.sv
module dcache_data_array import dcache_pkg::*; (
    input  logic                  clk,
    input  line_loc_t             row_i,
    input  logic                  fill_i,
    input  logic [MEM_DATA_W-1:0] fill_data_i,
    input  logic                  store_i,
    input  core_req_t             store_req_i,
    output logic [MEM_DATA_W-1:0] row_data_o
);

    localparam int ROW_BYTES = MEM_DATA_W / 8;

    logic [MEM_DATA_W-1:0] mem_q [2**BANK_ADDR_W];

    logic [BANK_ADDR_W-1:0] row_addr;
    logic [3:0]             word_mask;
    logic [ROW_BYTES-1:0]   store_mask;
    logic [MEM_DATA_W-1:0]  store_data;
    logic [ROW_BYTES-1:0]   wr_mask;
    logic [MEM_DATA_W-1:0]  wr_data;

    assign row_addr = row_i;

    // byte enables within the 32 bit word
    always_comb begin
        case (store_req_i.dtype)
            BYTE, BYTE_U: word_mask = 4'b0001;
            HALF, HALF_U: word_mask = 4'b0011;
            WORD:         word_mask = 4'b1111;
            default:      word_mask = 4'b0000;
        endcase
    end

    // move word and mask to their place in the beat
    assign store_mask = ROW_BYTES'(word_mask) << store_req_i.addr[3:0];
    assign store_data = MEM_DATA_W'(store_req_i.wdata) << {store_req_i.addr[3:0], 3'b000};

    // refill writes the whole row
    always_comb begin
        wr_mask = '0;
        wr_data = store_data;
        if (fill_i) begin
            wr_mask = '1;
            wr_data = fill_data_i;
        end else if (store_i) begin
            wr_mask = store_mask;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < ROW_BYTES; b++) begin
            if (wr_mask[b]) begin
                mem_q[row_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
        row_data_o <= mem_q[row_addr];
    end

    // refill beats only arrive while no store can be replayed
    assert property (@(posedge clk) !(fill_i && store_i));

endmodule

// File: dcache_load_align.sv
module dcache_load_align import dcache_pkg::*; (
    input  logic [MEM_DATA_W-1:0] row_data_i,
    input  mem_dtype_t            dtype_i,
    input  logic [3:0]            offset_i,
    output logic [DATA_W-1:0]     data_o
);

    logic [DATA_W-1:0] word;
    logic [1:0]        off;
    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic              misaligned;

    // word within the beat, then byte or half within the word
    assign word     = row_data_i[offset_i[3:2]*DATA_W +: DATA_W];
    assign off      = offset_i[1:0];
    assign byte_sel = word[off*8 +: 8];
    assign half_sel = word[off[1]*16 +: 16];

    always_comb begin
        case (dtype_i)
            HALF, HALF_U: misaligned = off[0];
            WORD:         misaligned = (off != 2'b00);
            default:      misaligned = 1'b0;
        endcase
    end

    // misaligned loads return zero
    always_comb begin
        data_o = '0;
        if (!misaligned) begin
            case (dtype_i)
                BYTE:    data_o = {{24{byte_sel[7]}}, byte_sel};
                BYTE_U:  data_o = {24'h0, byte_sel};
                HALF:    data_o = {{16{half_sel[15]}}, half_sel};
                HALF_U:  data_o = {16'h0, half_sel};
                WORD:    data_o = word;
                default: data_o = '0;
            endcase
        end
    end

endmodule

// File: dcache_ctrl.sv
module dcache_ctrl import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  core_req_t             req_i,
    output logic                  req_ready_o,
    input  logic                  hit_i,
    input  logic                  victim_dirty_i,
    input  logic [TAG_W-1:0]      victim_tag_i,
    output logic [ADDR_W-1:0]     lookup_addr_o,
    output logic                  fill_done_o,
    output logic [ADDR_W-1:0]     fill_addr_o,
    output logic                  mark_dirty_o,
    output line_loc_t             row_o,
    output logic                  fill_o,
    output logic                  store_o,
    output core_req_t             store_req_o,
    output mem_dtype_t            load_dtype_o,
    output logic [3:0]            load_offset_o,
    output logic                  rsp_valid_o,
    output logic                  mem_rd_valid_o,
    output logic [MEM_ADDR_W-1:0] mem_rd_addr_o,
    output logic                  mem_wr_valid_o,
    output logic [MEM_ADDR_W-1:0] mem_wr_addr_o,
    input  logic                  mem_rsp_valid_i
);

    typedef enum logic [2:0] {
        RESET,
        READY,
        EVICT,
        REFILL,
        REPLAY
    } state_t;

    state_t state_q;
    state_t state_d;

    core_req_t             pend_q;
    core_req_t             cur_req;
    logic [BEAT_W-1:0]     beat_q;
    logic                  rd_wait_q;
    logic                  wr_valid_q;
    logic [MEM_ADDR_W-1:0] wr_addr_q;
    logic                  rsp_valid_q;

    logic             accept;
    logic             miss;
    logic             last_beat;
    logic             load_now;
    logic [IDX_W-1:0] pend_set;

    // ------------------------------------------------------------
    // request decode
    // ------------------------------------------------------------

    // incoming request in READY, otherwise the one waiting on memory
    assign cur_req = (state_q == READY) ? req_i : pend_q;

    assign accept    = req_valid_i && req_ready_o;
    assign miss      = accept && !hit_i;
    assign last_beat = (beat_q == BEAT_W'(BEATS - 1));
    assign pend_set  = pend_q.addr[OFF_W +: IDX_W];

    assign store_o  = (accept && hit_i && req_i.write) || (state_q == REPLAY && pend_q.write);
    assign load_now = (accept && hit_i && !req_i.write) || (state_q == REPLAY && !pend_q.write);

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET: state_d = READY;
            READY: begin
                if (miss) begin
                    state_d = victim_dirty_i ? EVICT : REFILL;
                end
            end
            EVICT: begin
                if (last_beat) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (fill_o && last_beat) begin
                    state_d = REPLAY;
                end
            end
            REPLAY:  state_d = READY;
            default: state_d = RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= RESET;
            beat_q      <= '0;
            rd_wait_q   <= 1'b0;
            wr_valid_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            rsp_valid_q <= load_now;
            // victim row read lands one cycle later
            wr_valid_q  <= (state_q == EVICT);
            if (mem_rd_valid_o) begin
                rd_wait_q <= 1'b1;
            end else if (mem_rsp_valid_i) begin
                rd_wait_q <= 1'b0;
            end
            if (state_q == READY) begin
                beat_q <= '0;
            end else if (state_q == EVICT || fill_o) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            pend_q <= req_i;
        end
        if (state_q == EVICT) begin
            wr_addr_q <= {victim_tag_i, pend_set, beat_q};
        end
        // lines up with the synchronous array read
        load_dtype_o  <= cur_req.dtype;
        load_offset_o <= cur_req.addr[3:0];
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------

    assign req_ready_o   = (state_q == READY);
    assign rsp_valid_o   = rsp_valid_q;
    assign lookup_addr_o = cur_req.addr;
    assign store_req_o   = cur_req;
    assign mark_dirty_o  = store_o;

    assign fill_o      = (state_q == REFILL) && mem_rsp_valid_i;
    assign fill_done_o = fill_o && last_beat;
    assign fill_addr_o = pend_q.addr;

    always_comb begin
        if (state_q == EVICT || state_q == REFILL) begin
            row_o = '{set: pend_set, beat: beat_q};
        end else begin
            row_o = '{set: cur_req.addr[OFF_W +: IDX_W],
                      beat: cur_req.addr[OFF_W-1 -: BEAT_W]};
        end
    end

    // one read in flight, and none while the last victim beat goes out
    assign mem_rd_valid_o = (state_q == REFILL) && !rd_wait_q && !wr_valid_q;
    assign mem_rd_addr_o  = {pend_q.addr[ADDR_W-1:OFF_W], beat_q};

    assign mem_wr_valid_o = wr_valid_q;
    assign mem_wr_addr_o  = wr_addr_q;

    // core is held off while a miss is serviced
    assert property (@(posedge clk) disable iff (rst) miss |=> !req_ready_o);

    // stores never answer the core
    assert property (@(posedge clk) disable iff (rst) (accept && req_i.write) |=> !rsp_valid_o);

endmodule

// File: dcache_top.sv
module dcache_top import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  core_req_t             req_i,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,
    output logic [DATA_W-1:0]     rsp_data_o,
    output logic                  mem_rd_valid_o,
    output logic [MEM_ADDR_W-1:0] mem_rd_addr_o,
    input  logic                  mem_rsp_valid_i,
    input  logic [MEM_DATA_W-1:0] mem_rsp_data_i,
    output logic                  mem_wr_valid_o,
    output mem_wr_t               mem_wr_o
);

    logic [ADDR_W-1:0]     lookup_addr;
    logic                  hit;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    logic                  fill_done;
    logic [ADDR_W-1:0]     fill_addr;
    logic                  mark_dirty;
    line_loc_t             row;
    logic                  fill;
    logic                  store;
    core_req_t             store_req;
    mem_dtype_t            load_dtype;
    logic [3:0]            load_offset;
    logic [MEM_DATA_W-1:0] row_data;
    logic [MEM_ADDR_W-1:0] mem_wr_addr;

    // victim row read doubles as the writeback beat
    assign mem_wr_o = '{addr: mem_wr_addr, data: row_data};

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .hit_i           (hit),
        .victim_dirty_i  (victim_dirty),
        .victim_tag_i    (victim_tag),
        .lookup_addr_o   (lookup_addr),
        .fill_done_o     (fill_done),
        .fill_addr_o     (fill_addr),
        .mark_dirty_o    (mark_dirty),
        .row_o           (row),
        .fill_o          (fill),
        .store_o         (store),
        .store_req_o     (store_req),
        .load_dtype_o    (load_dtype),
        .load_offset_o   (load_offset),
        .rsp_valid_o     (rsp_valid_o),
        .mem_rd_valid_o  (mem_rd_valid_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_wr_valid_o  (mem_wr_valid_o),
        .mem_wr_addr_o   (mem_wr_addr),
        .mem_rsp_valid_i (mem_rsp_valid_i)
    );

    dcache_tag_array u_tag_array (
        .clk            (clk),
        .rst            (rst),
        .lookup_addr_i  (lookup_addr),
        .fill_done_i    (fill_done),
        .fill_addr_i    (fill_addr),
        .mark_dirty_i   (mark_dirty),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_array u_data_array (
        .clk         (clk),
        .row_i       (row),
        .fill_i      (fill),
        .fill_data_i (mem_rsp_data_i),
        .store_i     (store),
        .store_req_i (store_req),
        .row_data_o  (row_data)
    );

    dcache_load_align u_load_align (
        .row_data_i (row_data),
        .dtype_i    (load_dtype),
        .offset_i   (load_offset),
        .data_o     (rsp_data_o)
    );

endmodule

// File: tb_mem_model.sv
module tb_mem_model import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rd_valid_i,
    input  logic [MEM_ADDR_W-1:0] rd_addr_i,
    output logic                  rsp_valid_o,
    output logic [MEM_DATA_W-1:0] rsp_data_o,
    input  logic                  wr_valid_i,
    input  mem_wr_t               wr_i,
    output int                    rd_beats_o,
    output int                    wr_beats_o
);
    timeunit 1ns;
    timeprecision 1ns;

    // only written blocks are kept, the rest follow the fill rule
    logic [MEM_DATA_W-1:0] store_q [logic [MEM_ADDR_W-1:0]];
    integer                seed;
    int                    lat;
    logic [MEM_DATA_W-1:0] rd_data;

    function automatic logic [MEM_DATA_W-1:0] block_value(input logic [MEM_ADDR_W-1:0] blk);
        logic [MEM_DATA_W-1:0] v;
        if (store_q.exists(blk)) begin
            return store_q[blk];
        end
        // each word holds its own byte address xor 5a5a0000
        for (int i = 0; i < 4; i++) begin
            v[i*32 +: 32] = {blk, 2'(i), 2'b00} ^ 32'h5a5a0000;
        end
        return v;
    endfunction

    initial begin
        seed        = 32'h1373dadd;
        rsp_valid_o = 1'b0;
        rsp_data_o  = '0;
        rd_beats_o  = 0;
        forever begin
            @(negedge clk);
            if (rd_valid_i) begin
                rd_beats_o = rd_beats_o + 1;
                lat = 1 + ($unsigned($random(seed)) % 4);
                rd_data = block_value(rd_addr_i);
                repeat (lat) @(posedge clk);
                #10 rsp_data_o = rd_data;
                rsp_valid_o = 1'b1;
                @(posedge clk);
                #10 rsp_valid_o = 1'b0;
            end
        end
    end

    // writeback beats are taken at once
    initial begin
        wr_beats_o = 0;
        forever begin
            @(negedge clk);
            if (wr_valid_i) begin
                store_q[wr_i.addr] = wr_i.data;
                wr_beats_o = wr_beats_o + 1;
            end
        end
    end

endmodule

// File: tb_dcache.sv
module tb_dcache import dcache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    core_req_t             req;
    logic                  req_ready;
    logic                  rsp_valid;
    logic [DATA_W-1:0]     rsp_data;
    logic                  mem_rd_valid;
    logic [MEM_ADDR_W-1:0] mem_rd_addr;
    logic                  mem_rsp_valid;
    logic [MEM_DATA_W-1:0] mem_rsp_data;
    logic                  mem_wr_valid;
    mem_wr_t               mem_wr;
    int                    rd_beats;
    int                    wr_beats;

    // op dtype addr wdata expected rd_beats wr_beats
    logic [31:0] pat [0:255];
    int          errors;
    int          tests;
    int          err_before;
    logic        timed_out;
    logic [31:0] acc_addr;
    logic [3:0]  beats_read;

    dcache_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .req_ready_o     (req_ready),
        .rsp_valid_o     (rsp_valid),
        .rsp_data_o      (rsp_data),
        .mem_rd_valid_o  (mem_rd_valid),
        .mem_rd_addr_o   (mem_rd_addr),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_data_i  (mem_rsp_data),
        .mem_wr_valid_o  (mem_wr_valid),
        .mem_wr_o        (mem_wr)
    );

    tb_mem_model u_mem (
        .clk         (clk),
        .rd_valid_i  (mem_rd_valid),
        .rd_addr_i   (mem_rd_addr),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_data_o  (mem_rsp_data),
        .wr_valid_i  (mem_wr_valid),
        .wr_i        (mem_wr),
        .rd_beats_o  (rd_beats),
        .wr_beats_o  (wr_beats)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // every refill read targets a block of the missed line
    always @(negedge clk) begin
        if (mem_rd_valid === 1'b1) begin
            check_value("mem_rd_addr_o", 32'(mem_rd_addr[MEM_ADDR_W-1:BEAT_W]),
                        32'(acc_addr[ADDR_W-1:OFF_W]));
            beats_read[mem_rd_addr[BEAT_W-1:0]] = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // one core access
    // ------------------------------------------------------------
    task automatic run_access(input logic op, input logic [2:0] dt, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp,
                              input int rd_exp, input int wr_exp);
        int   rd0;
        int   wr0;
        logic done;
        rd0 = rd_beats;
        wr0 = wr_beats;
        acc_addr   = addr;
        beats_read = '0;
        @(posedge clk);
        #10;
        req_valid = 1'b1;
        req = '{addr: addr, wdata: wdata, dtype: mem_dtype_t'(dt), write: op};
        done = 1'b0;
        for (int n = 0; n < 200 && !done; n++) begin
            @(negedge clk);
            done = req_ready;
        end
        if (!done) begin
            $display("timeout: request at %h was never accepted", addr);
            timed_out = 1'b1;
            errors = errors + 1;
            return;
        end
        @(posedge clk);
        #10 req_valid = 1'b0;
        done = 1'b0;
        // loads end on the response, stores when the cache is ready again
        for (int n = 0; n < 200 && !done; n++) begin
            @(negedge clk);
            done = op ? req_ready : rsp_valid;
        end
        if (!done) begin
            $display("timeout: access at %h did not complete", addr);
            timed_out = 1'b1;
            errors = errors + 1;
            return;
        end
        if (!op) begin
            check_value("rsp_data_o", rsp_data, exp);
        end
        check_value("mem_rd_valid_o count", 32'(rd_beats - rd0), 32'(rd_exp));
        check_value("mem_wr_valid_o count", 32'(wr_beats - wr0), 32'(wr_exp));
        if (rd_exp != 0) begin
            check_value("mem_rd_addr_o beats", 32'(beats_read), 32'hf);
        end
    endtask

    initial begin
        logic ready_seen;
        int   idx;
        errors     = 0;
        tests      = 0;
        timed_out  = 1'b0;
        acc_addr   = '0;
        beats_read = '0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        $readmemh("dcache_patterns.txt", pat);

        // strobes stay quiet until ready after reset
        repeat (3) @(posedge clk);
        #10 rst = 1'b0;
        ready_seen = 1'b0;
        for (int n = 0; n < 20 && !ready_seen; n++) begin
            @(negedge clk);
            check_value("rsp_valid_o", 32'(rsp_valid), 32'h0);
            check_value("mem_rd_valid_o", 32'(mem_rd_valid), 32'h0);
            check_value("mem_wr_valid_o", 32'(mem_wr_valid), 32'h0);
            ready_seen = req_ready;
        end
        if (!ready_seen) begin
            $display("timeout: req_ready_o never rose after reset");
            errors = errors + 1;
            timed_out = 1'b1;
        end
        tests = tests + 1;
        $display("test %0d reset: %s", tests, (errors == 0) ? "ok" : "bad");

        idx = 0;
        while (!timed_out && idx < 250 && pat[idx] <= 32'h1) begin
            err_before = errors;
            run_access(pat[idx][0], pat[idx+1][2:0], pat[idx+2], pat[idx+3], pat[idx+4],
                       int'(pat[idx+5]), int'(pat[idx+6]));
            tests = tests + 1;
            $display("test %0d %s addr %h: %s", tests, pat[idx][0] ? "store" : "load",
                     pat[idx+2], (errors == err_before) ? "ok" : "bad");
            idx = idx + 7;
        end

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: dcache_patterns.txt
// op (0 load, 1 store) dtype addr wdata expected refill_beats writeback_beats
// dtype: 0 byte, 1 half, 2 word, 4 byte_u, 5 half_u; op f ends the list
0 2 00000100 00000000 5a5a0100 4 0
0 2 00000104 00000000 5a5a0104 0 0
0 0 00000080 00000000 ffffff80 4 0
0 4 00000080 00000000 00000080 0 0
0 1 00008000 00000000 ffff8000 4 0
0 5 00008000 00000000 00008000 0 0
0 1 00008002 00000000 00005a5a 0 0
1 2 00000104 11223344 00000000 0 0
0 2 00000104 00000000 11223344 0 0
1 0 00000101 000000ab 00000000 0 0
0 2 00000100 00000000 5a5aab00 0 0
1 1 0000010a 0000beef 00000000 0 0
0 1 0000010a 00000000 ffffbeef 0 0
0 2 00000108 00000000 beef0108 0 0
1 2 000001c0 cafef00d 00000000 4 0
0 2 000001c0 00000000 cafef00d 0 0
0 2 000003c0 00000000 5a5a03c0 4 4
0 2 000001c0 00000000 cafef00d 4 0
0 1 00000101 00000000 00000000 0 0
0 2 00000102 00000000 00000000 0 0
0 5 00000103 00000000 00000000 0 0
f 0 0 0 0 0 0

// File: dcache_top.f
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_load_align.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
verilator --binary --timing --assert --top-module tb_dcache -f dcache_top.f -o sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
